// ==== build.f ====
+incdir+tb
verilog/cpuCtrlPkg.sv
verilog/instructionDecoder.sv
verilog/controlSequencer.sv
verilog/regfileAOutputLogic.sv
verilog/aluOutputLogic.sv
verilog/memoryOutputLogic.sv
verilog/controlUnit.sv
tb/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module controlUnitTb \
    -f build.f -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/controlUnitSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb/controlUnitVectors.svh ====
`ifndef CONTROL_UNIT_VECTORS_SVH
`define CONTROL_UNIT_VECTORS_SVH

// columns: instruction word, interruptPending, stall, states from DECODE on, expected codes.
// codes are tagged by bus, 1 = port A, 2 = ALU, 3 = memory, zero means no code.
logic [31:0] rowWord[$];
logic        rowIrq[$];
logic        rowStall[$];
logic [3:0]  rowStates[$];
logic [39:0] rowCodes[$];

function automatic logic [7:0] portACode(regfileAControl value);
    return {4'h1, value};
endfunction

function automatic logic [7:0] aluCode(aluControl value);
    return {4'h2, value};
endfunction

function automatic logic [7:0] memCode(memoryControl value);
    return {4'h3, 2'b00, value};
endfunction

task automatic addRow(input logic [31:0] word, input logic irq, input logic stall,
                      input logic [3:0] pathLength, input logic [7:0] c0 = 8'h00,
                      input logic [7:0] c1 = 8'h00, input logic [7:0] c2 = 8'h00,
                      input logic [7:0] c3 = 8'h00, input logic [7:0] c4 = 8'h00);
    rowWord.push_back(word);
    rowIrq.push_back(irq);
    rowStall.push_back(stall);
    rowStates.push_back(pathLength);
    rowCodes.push_back({c0, c1, c2, c3, c4}); // first code in the top byte.
endtask

task automatic buildVectorTable();
    addRow(32'h10123456, 1'b0, 1'b0, 4'd4, aluCode(ALU_ADD), portACode(RESULT_DRL));
    addRow(32'h110000ff, 1'b0, 1'b0, 4'd4, aluCode(ALU_ADD), portACode(RESULT_DRL));
    addRow(32'h12a5a5a5, 1'b0, 1'b0, 4'd4, aluCode(ALU_SUB), portACode(RESULT_DRL));
    addRow(32'h14000001, 1'b0, 1'b0, 4'd4, aluCode(ALU_AND), portACode(RESULT_DRL));
    addRow(32'h17ffffff, 1'b0, 1'b0, 4'd4, aluCode(ALU_OR), portACode(RESULT_DRL));
    addRow(32'h18345678, 1'b0, 1'b0, 4'd4, aluCode(ALU_XOR), portACode(RESULT_DRL));
    addRow(32'h1b000010, 1'b0, 1'b0, 4'd4, aluCode(ALU_SHL), portACode(RESULT_DRL));
    addRow(32'h1c5a0000, 1'b0, 1'b0, 4'd4, aluCode(ALU_NOT), portACode(RESULT_DRL));
    addRow(32'h40001234, 1'b0, 1'b0, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(DWORD_DRL));
    addRow(32'h41000004, 1'b0, 1'b0, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(SBYTE_DRL));
    addRow(32'h42000008, 1'b0, 1'b0, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(SWORD_DRL));
    addRow(32'h4300000c, 1'b0, 1'b0, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(UBYTE_DRL));
    addRow(32'h44000010, 1'b0, 1'b0, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(UWORD_DRL));
    addRow(32'h48000020, 1'b0, 1'b0, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_WRITE));
    addRow(32'h70000003, 1'b0, 1'b0, 4'd2, portACode(SYSREG_DRL));
    addRow(32'h78abcd00, 1'b0, 1'b0, 4'd3, portACode(BREG_DRL));
    addRow(32'h60000040, 1'b0, 1'b0, 4'd3, portACode(NEXTPC_LR));
    addRow(32'h00000000, 1'b0, 1'b0, 4'd2);
    addRow(32'h05000000, 1'b0, 1'b0, 4'd3, portACode(NEXTPC_EPC)); // unknown opcode.
    addRow(32'h12000001, 1'b1, 1'b0, 4'd5, aluCode(ALU_SUB), portACode(RESULT_DRL),
           portACode(NEXTPC_EPC));
    addRow(32'h44000014, 1'b1, 1'b0, 4'd7, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(UWORD_DRL), portACode(NEXTPC_EPC));
    addRow(32'h78001111, 1'b1, 1'b0, 4'd4, portACode(BREG_DRL), portACode(NEXTPC_EPC));
    addRow(32'h18000f0f, 1'b0, 1'b1, 4'd4, aluCode(ALU_XOR), portACode(RESULT_DRL));
    addRow(32'h41000030, 1'b0, 1'b1, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_READ), portACode(SBYTE_DRL));
    addRow(32'h48000034, 1'b0, 1'b1, 4'd6, aluCode(ALU_ADDRESS), memCode(MEM_ADDRESS),
           memCode(MEM_WRITE));
    addRow(32'h60000080, 1'b1, 1'b1, 4'd4, portACode(NEXTPC_LR), portACode(NEXTPC_EPC));
    addRow(32'ha3000000, 1'b0, 1'b1, 4'd3, portACode(NEXTPC_EPC));
    addRow(32'h70000001, 1'b0, 1'b1, 4'd2, portACode(SYSREG_DRL));
    addRow(32'h00ffffff, 1'b0, 1'b1, 4'd2);
endtask

`endif

// ==== tb/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb
    import cpuCtrlPkg::*;
();

    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 200;

    logic                         clk;
    logic                         reset;
    logic                         enable;
    logic [INSTRUCTION_WIDTH-1:0] instructionWord;
    logic                         fetchValid;
    logic                         interruptPending;
    logic                         fetchRequest;
    states                        state;
    regfileAControl               regfileAOut;
    aluControl                    aluOut;
    memoryControl                 memoryOut;

    int         errorCount;
    int         checkCount;
    int         stateCount;
    integer     seed;
    logic       lastEnable;
    logic       timedOut;
    logic [7:0] trace[$];
    logic [7:0] expected[$];

    `include "controlUnitVectors.svh"

    controlUnit controlUnit_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .instructionWord  (instructionWord),
        .fetchValid       (fetchValid),
        .interruptPending (interruptPending),
        .fetchRequest     (fetchRequest),
        .state            (state),
        .regfileAControl  (regfileAOut),
        .aluControl       (aluOut),
        .memoryControl    (memoryOut)
    );

    always #HALF_PERIOD clk = ~clk;

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expectedValue,
                              input string what);
        checkCount++;
        if (actual !== expectedValue) begin
            errorCount++;
            $display("** Error at time %0t: %s, expected %0h, got %0h",
                     $time, what, expectedValue, actual);
        end
    endtask

    task automatic waitForFetchRequest();
        int cycles;
        cycles = 0;
        while (!fetchRequest && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!fetchRequest) begin
            $display("Timed out waiting for fetchRequest before the next fetch.");
            timedOut = 1'b1;
            errorCount++;
        end
    endtask

    task automatic collectTrace(input logic [31:0] word, input logic stall);
        int             cycles;
        logic           done;
        states          heldState;
        regfileAControl heldPortA;
        aluControl      heldAlu;
        memoryControl   heldMem;
        cycles = 0;
        done = 1'b0;
        stateCount = 0;
        heldState = FETCH;
        heldPortA = NO_OP;
        heldAlu = ALU_NONE;
        heldMem = MEM_NONE;
        trace.delete();
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (lastEnable) begin
                // codes come from enabled edges only.
                if (state != FETCH) begin
                    stateCount++;
                end
                if (regfileAOut != NO_OP) begin
                    trace.push_back(portACode(regfileAOut));
                end
                if (aluOut != ALU_NONE) begin
                    trace.push_back(aluCode(aluOut));
                end
                if (memoryOut != MEM_NONE) begin
                    trace.push_back(memCode(memoryOut));
                end
                heldState = state;
                heldPortA = regfileAOut;
                heldAlu = aluOut;
                heldMem = memoryOut;
                done = fetchRequest; // last code shows as FETCH returns.
            end else begin
                // outputs must hold while stalled.
                checkValue(32'(state), 32'(heldState), "state during stall");
                checkValue(32'(regfileAOut), 32'(heldPortA), "port A control during stall");
                checkValue(32'(aluOut), 32'(heldAlu), "ALU control during stall");
                checkValue(32'(memoryOut), 32'(heldMem), "memory control during stall");
            end
            fetchValid = 1'b0;
            enable = stall ? (($random(seed) & 3) != 0) : 1'b1;
            lastEnable = enable;
        end
        if (!done) begin
            $display("Timed out waiting for fetchRequest to return after word %h.", word);
            timedOut = 1'b1;
            errorCount++;
        end
    endtask

    task automatic compareTrace(input int row);
        string       tag;
        logic [39:0] packedCodes;
        tag = $sformatf("row %0d", row);
        packedCodes = rowCodes[row];
        expected.delete();
        for (int i = 0; i < 5; i++) begin
            if (packedCodes[39:32] != 8'h00) begin
                expected.push_back(packedCodes[39:32]);
            end
            packedCodes = packedCodes << 8;
        end
        checkValue(32'(trace.size()), 32'(expected.size()), {tag, " code count"});
        for (int i = 0; i < trace.size() && i < expected.size(); i++) begin
            checkValue(32'(trace[i]), 32'(expected[i]), {tag, $sformatf(" code %0d", i)});
        end
        if (!rowStall[row]) begin
            checkValue(32'(stateCount), 32'(rowStates[row]), {tag, " state count"});
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        enable = 1'b1;
        instructionWord = '0;
        fetchValid = 1'b0;
        interruptPending = 1'b0;
        errorCount = 0;
        checkCount = 0;
        stateCount = 0;
        seed = 37211;
        lastEnable = 1'b1;
        timedOut = 1'b0;
        buildVectorTable();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        checkValue(32'(fetchRequest), 32'(1'b1), "fetchRequest after reset");
        checkValue(32'(state), 32'(FETCH), "state after reset");
        checkValue(32'(regfileAOut), 32'(NO_OP), "port A control after reset");
        checkValue(32'(aluOut), 32'(ALU_NONE), "ALU control after reset");
        checkValue(32'(memoryOut), 32'(MEM_NONE), "memory control after reset");
        reset = 1'b0;

        for (int row = 0; row < rowWord.size() && !timedOut; row++) begin
            waitForFetchRequest();
            if (!timedOut) begin
                instructionWord = rowWord[row];
                fetchValid = 1'b1;
                interruptPending = rowIrq[row];
                enable = 1'b1;
                lastEnable = 1'b1;
                collectTrace(rowWord[row], rowStall[row]);
                interruptPending = 1'b0;
                enable = 1'b1;
                lastEnable = 1'b1;
                if (!timedOut) begin
                    compareTrace(row);
                end
            end
        end

        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/aluOutputLogic.sv ====
`timescale 1ns/1ps

module aluOutputLogic
    import cpuCtrlPkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  opcodes                  instruction,
    input  states                   state,
    output cpuCtrlPkg::aluControl   aluControl
);

    cpuCtrlPkg::aluControl aluControlNext;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            aluControl <= ALU_NONE;
        end else if (enable) begin
            aluControl <= aluControlNext;
        end
    end

    always_comb begin
        aluControlNext = ALU_NONE;

        if (state == EXECUTE0) begin
            case (instruction)
                ADD_R, ADD_I: aluControlNext = ALU_ADD;
                SUB_R:        aluControlNext = ALU_SUB;
                AND_R:        aluControlNext = ALU_AND;
                OR_I:         aluControlNext = ALU_OR;
                XOR_R:        aluControlNext = ALU_XOR;
                SHL_I:        aluControlNext = ALU_SHL;
                NOT_R:        aluControlNext = ALU_NOT;
                default:      aluControlNext = ALU_NONE;
            endcase
        end else if (state == MEMORY0 && isMemoryOp(instruction)) begin
            aluControlNext = ALU_ADDRESS; // effective address.
        end
    end

endmodule

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer
    import cpuCtrlPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   enable,
    input  logic   fetchValid,
    input  opcodes opcode,
    input  logic   exceptionPending,
    input  logic   interruptPending,
    output states  state,
    output logic   fetchRequest,
    output logic   loadInstruction
);

    states stateNext;

    assign fetchRequest    = (state == FETCH);
    assign loadInstruction = fetchRequest && fetchValid && enable;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else if (enable) begin
            state <= stateNext; // hold on stall.
        end
    end

    always_comb begin
        stateNext = state;

        case (state)
            FETCH: begin
                if (fetchValid) begin
                    stateNext = DECODE;
                end
            end

            // path chosen by instruction family.
            DECODE: begin
                if (isAluOp(opcode) || opcode == BRL_RR) begin
                    stateNext = EXECUTE0;
                end else if (opcode == MUI_I) begin
                    stateNext = LOAD;
                end else if (isMemoryOp(opcode)) begin
                    stateNext = MEMORY0;
                end else begin
                    stateNext = WRITEBACK;
                end
            end

            LOAD: stateNext = WRITEBACK;

            EXECUTE0: begin
                if (isAluOp(opcode)) begin
                    stateNext = EXECUTE1;
                end else begin
                    stateNext = WRITEBACK; // branch and link.
                end
            end

            EXECUTE1: stateNext = WRITEBACK;

            MEMORY0: stateNext = MEMORY1;
            MEMORY1: stateNext = MEMORY2;
            MEMORY2: stateNext = MEMORY3;
            MEMORY3: stateNext = WRITEBACK;

            WRITEBACK: begin
                if (exceptionPending || interruptPending) begin
                    stateNext = INTERRUPT;
                end else begin
                    stateNext = FETCH;
                end
            end

            INTERRUPT: stateNext = FETCH;

            default: stateNext = FETCH;
        endcase
    end

endmodule

// ==== verilog/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
    import cpuCtrlPkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         enable,
    input  logic [INSTRUCTION_WIDTH-1:0] instructionWord,
    input  logic                         fetchValid,
    input  logic                         interruptPending,
    output logic                         fetchRequest,
    output states                        state,
    output cpuCtrlPkg::regfileAControl   regfileAControl,
    output cpuCtrlPkg::aluControl        aluControl,
    output cpuCtrlPkg::memoryControl     memoryControl
);

    opcodes opcode;
    logic   exceptionPending;
    logic   loadInstruction;

    instructionDecoder instructionDecoder_i (
        .clk              (clk),
        .reset            (reset),
        .instructionWord  (instructionWord),
        .loadInstruction  (loadInstruction),
        .opcode           (opcode),
        .exceptionPending (exceptionPending)
    );

    controlSequencer controlSequencer_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .fetchValid       (fetchValid),
        .opcode           (opcode),
        .exceptionPending (exceptionPending),
        .interruptPending (interruptPending),
        .state            (state),
        .fetchRequest     (fetchRequest),
        .loadInstruction  (loadInstruction)
    );

    regfileAOutputLogic regfileAOutputLogic_i (
        .clk              (clk),
        .reset            (reset),
        .enable           (enable),
        .instruction      (opcode),
        .state            (state),
        .exceptionPending (exceptionPending),
        .interruptPending (interruptPending),
        .regfileAControl  (regfileAControl)
    );

    aluOutputLogic aluOutputLogic_i (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .instruction (opcode),
        .state       (state),
        .aluControl  (aluControl)
    );

    memoryOutputLogic memoryOutputLogic_i (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .instruction   (opcode),
        .state         (state),
        .memoryControl (memoryControl)
    );

endmodule

// ==== verilog/cpuCtrlPkg.sv ====
package cpuCtrlPkg;

    localparam int INSTRUCTION_WIDTH = 32;
    localparam int OPCODE_MSB        = 31;
    localparam int OPCODE_LSB        = 24;

    // values are the opcode field encodings.
    typedef enum logic [7:0] {
        NOP     = 8'h00,
        ADD_R   = 8'h10,
        ADD_I   = 8'h11,
        SUB_R   = 8'h12,
        AND_R   = 8'h14,
        OR_I    = 8'h17,
        XOR_R   = 8'h18,
        SHL_I   = 8'h1b,
        NOT_R   = 8'h1c,
        LDD_RO  = 8'h40,
        LDBS_RO = 8'h41,
        LDWS_RO = 8'h42,
        LDBU_RO = 8'h43,
        LDWU_RO = 8'h44,
        STD_RO  = 8'h48,
        BRL_RR  = 8'h60,
        LSR_R   = 8'h70,
        MUI_I   = 8'h78,
        ILLEGAL = 8'hff
    } opcodes;

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        LOAD,
        EXECUTE0,
        EXECUTE1,
        MEMORY0,
        MEMORY1,
        MEMORY2,
        MEMORY3,
        WRITEBACK,
        INTERRUPT
    } states;

    typedef enum logic [3:0] {
        NO_OP,
        SYSREG_DRL,
        BREG_DRL,
        NEXTPC_LR,
        RESULT_DRL,
        DWORD_DRL,
        SBYTE_DRL,
        SWORD_DRL,
        UBYTE_DRL,
        UWORD_DRL,
        NEXTPC_EPC
    } regfileAControl;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_NOT,
        ALU_ADDRESS
    } aluControl;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_ADDRESS,
        MEM_READ,
        MEM_WRITE
    } memoryControl;

    // instruction families used by the sequencer and output blocks.
    function automatic logic isAluOp(opcodes op);
        case (op)
            ADD_R, ADD_I, SUB_R, AND_R, OR_I, XOR_R, SHL_I, NOT_R: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic isLoad(opcodes op);
        case (op)
            LDD_RO, LDBS_RO, LDWS_RO, LDBU_RO, LDWU_RO: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic isMemoryOp(opcodes op);
        return isLoad(op) || (op == STD_RO);
    endfunction

endpackage

// ==== verilog/instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder
    import cpuCtrlPkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [INSTRUCTION_WIDTH-1:0] instructionWord,
    input  logic                         loadInstruction,
    output opcodes                       opcode,
    output logic                         exceptionPending
);

    logic [OPCODE_MSB-OPCODE_LSB:0] opcodeField;
    opcodes                         opcodeDecoded;

    // only the listed encodings are legal.
    always_comb begin
        opcodeField = instructionWord[OPCODE_MSB:OPCODE_LSB];
        case (opcodeField)
            NOP,
            ADD_R,
            ADD_I,
            SUB_R,
            AND_R,
            OR_I,
            XOR_R,
            SHL_I,
            NOT_R,
            LDD_RO,
            LDBS_RO,
            LDWS_RO,
            LDBU_RO,
            LDWU_RO,
            STD_RO,
            BRL_RR,
            LSR_R,
            MUI_I:   opcodeDecoded = opcodes'(opcodeField);
            default: opcodeDecoded = ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            opcode           <= NOP;
            exceptionPending <= 1'b0;
        end else if (loadInstruction) begin
            opcode           <= opcodeDecoded;
            exceptionPending <= (opcodeDecoded == ILLEGAL); // cleared by next load.
        end
    end

endmodule

// ==== verilog/memoryOutputLogic.sv ====
`timescale 1ns/1ps

module memoryOutputLogic
    import cpuCtrlPkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       enable,
    input  opcodes                     instruction,
    input  states                      state,
    output cpuCtrlPkg::memoryControl   memoryControl
);

    cpuCtrlPkg::memoryControl memoryControlNext;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memoryControl <= MEM_NONE;
        end else if (enable) begin
            memoryControl <= memoryControlNext;
        end
    end

    always_comb begin
        memoryControlNext = MEM_NONE;

        if (state == MEMORY1 && isMemoryOp(instruction)) begin
            memoryControlNext = MEM_ADDRESS;
        end else if (state == MEMORY2) begin
            if (isLoad(instruction)) begin
                memoryControlNext = MEM_READ;
            end else if (instruction == STD_RO) begin
                memoryControlNext = MEM_WRITE; // store only.
            end
        end
    end

endmodule

// ==== verilog/regfileAOutputLogic.sv ====
`timescale 1ns/1ps

module regfileAOutputLogic
    import cpuCtrlPkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        enable,
    input  opcodes                      instruction,
    input  states                       state,
    input  logic                        exceptionPending,
    input  logic                        interruptPending,
    output cpuCtrlPkg::regfileAControl  regfileAControl
);

    cpuCtrlPkg::regfileAControl regfileAControlNext;
    logic                       divertTaken;

    // cause seen in writeback, qualifies the epc save.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            divertTaken <= 1'b0;
        end else if (enable && state == WRITEBACK) begin
            divertTaken <= exceptionPending || interruptPending;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            regfileAControl <= NO_OP;
        end else if (enable) begin
            regfileAControl <= regfileAControlNext;
        end
    end

    always_comb begin
        regfileAControlNext = NO_OP;

        case (state)
            DECODE: begin
                if (instruction == LSR_R) begin
                    regfileAControlNext = SYSREG_DRL;
                end
            end

            LOAD: begin
                if (instruction == MUI_I) begin
                    regfileAControlNext = BREG_DRL;
                end
            end

            EXECUTE0: begin
                if (instruction == BRL_RR) begin
                    regfileAControlNext = NEXTPC_LR;
                end
            end

            EXECUTE1: begin
                if (isAluOp(instruction)) begin
                    regfileAControlNext = RESULT_DRL;
                end
            end

            // load width and sign.
            MEMORY3: begin
                case (instruction)
                    LDD_RO:  regfileAControlNext = DWORD_DRL;
                    LDBS_RO: regfileAControlNext = SBYTE_DRL;
                    LDWS_RO: regfileAControlNext = SWORD_DRL;
                    LDBU_RO: regfileAControlNext = UBYTE_DRL;
                    LDWU_RO: regfileAControlNext = UWORD_DRL;
                    default: regfileAControlNext = NO_OP;
                endcase
            end

            INTERRUPT: begin
                if (divertTaken) begin
                    regfileAControlNext = NEXTPC_EPC;
                end
            end

            default: regfileAControlNext = NO_OP;
        endcase
    end

endmodule
